//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f build.f --top-module wdc_tb -o wdc_sim

run: compile
	@out=$$(./obj_dir/wdc_sim); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

//--- build.f
design/wdc_pkg.sv
design/wdc_regs.sv
design/wvb_trigger.sv
design/wvb_buffer.sv
design/wvb_reader.sv
design/wdc_top.sv
test/wdc_checker.sv
test/wdc_tb.sv

//--- design/wdc_pkg.sv
// ----------------------------------------------------------------------
// shared constants, register map and readout word layout
// one waveform per channel, at most pre+1+post = 63 samples
// ----------------------------------------------------------------------
`default_nettype none

package wdc_pkg;

  // sizes
  localparam int N_CHANNELS    = 2;
  localparam int CHAN_WIDTH    = 1;
  localparam int SAMPLE_WIDTH  = 12;
  localparam int LTC_WIDTH     = 48;
  localparam int WVB_DEPTH     = 64;
  localparam int WVB_ADR_WIDTH = 6;
  localparam int PRE_MAX       = 15;
  localparam int POST_MAX      = 47;

  localparam logic [15:0] FW_VNUM = 16'h000a;

  // global registers
  localparam logic [11:0] ADR_VERSION = 12'hfff;
  localparam logic [11:0] ADR_SW_TRIG = 12'hffc;
  localparam logic [11:0] ADR_ARM     = 12'hffa;
  localparam logic [11:0] ADR_ARMED   = 12'hff9;

  // per-channel page, channel c sits at page f-c
  localparam logic [3:0] ADR_PAGE_CH0 = 4'hf;
  localparam logic [7:0] ADR_TRIG_SET = 8'hfe;
  localparam logic [7:0] ADR_THRESH   = 8'hfd;
  localparam logic [7:0] ADR_POST     = 8'hf5;
  localparam logic [7:0] ADR_PRE      = 8'hf4;

  // readout word tags
  localparam logic [1:0] TAG_HDR = 2'b10;
  localparam logic [1:0] TAG_SMP = 2'b01;

  typedef struct packed {
    logic        wr_en;
    logic        rd_en;
    logic [11:0] addr;
    logic [15:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        et;
    logic        gt;
    logic        lt;
    logic        thresh_en;
    logic [11:0] threshold;
    logic [3:0]  pre;
    logic [5:0]  post;
  } trig_cfg_t;

  typedef struct packed {
    logic [1:0]  tag;
    logic        chan;
    logic [5:0]  len;
    logic        sw;
    logic [21:0] ltc;
  } hdr_word_t;

  typedef struct packed {
    logic [1:0]  tag;
    logic        last;
    logic [5:0]  index;
    logic [10:0] pad;
    logic [11:0] sample;
  } smp_word_t;

  // same 32 bits, tag says which view applies
  typedef union packed {
    hdr_word_t hdr;
    smp_word_t smp;
  } rdout_word_u;

endpackage

`default_nettype wire

//--- design/wdc_regs.sv
// ----------------------------------------------------------------------
// register file on 12-bit addresses, read data one cycle after rd_en
// arm and sw trigger writes give single-cycle pulses, bit i = channel i
// pre and post writes saturate at PRE_MAX and POST_MAX
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module wdc_regs (
  input  logic                                            i_lclk,
  input  logic                                            i_lclk_rst,
  input  wdc_pkg::reg_req_t                               i_reg,
  input  logic [wdc_pkg::N_CHANNELS-1:0]                  i_armed,
  output logic [15:0]                                     o_rd_data,
  output wdc_pkg::trig_cfg_t [wdc_pkg::N_CHANNELS-1:0]    o_cfg,
  output logic [wdc_pkg::N_CHANNELS-1:0]                  o_arm,
  output logic [wdc_pkg::N_CHANNELS-1:0]                  o_sw_trig
);

  wdc_pkg::trig_cfg_t [wdc_pkg::N_CHANNELS-1:0] cfg_q;
  logic [wdc_pkg::N_CHANNELS-1:0] page_hit;
  logic [15:0] rd_val;

  assign o_cfg = cfg_q;

  // which channel page the address falls in
  always_comb begin
    for (int c = 0; c < wdc_pkg::N_CHANNELS; c++) begin
      page_hit[c] = (i_reg.addr[11:8] == (wdc_pkg::ADR_PAGE_CH0 - 4'(c)));
    end
  end

  // read decode, unknown addresses give zero
  always_comb begin
    rd_val = '0;
    case (i_reg.addr)
      wdc_pkg::ADR_VERSION: rd_val = wdc_pkg::FW_VNUM;
      wdc_pkg::ADR_ARMED:   rd_val = 16'(i_armed);
      default: begin
        for (int c = 0; c < wdc_pkg::N_CHANNELS; c++) begin
          if (page_hit[c]) begin
            case (i_reg.addr[7:0])
              wdc_pkg::ADR_TRIG_SET: rd_val = {12'd0, cfg_q[c].thresh_en, cfg_q[c].lt,
                                               cfg_q[c].gt, cfg_q[c].et};
              wdc_pkg::ADR_THRESH:   rd_val = 16'(cfg_q[c].threshold);
              wdc_pkg::ADR_POST:     rd_val = 16'(cfg_q[c].post);
              wdc_pkg::ADR_PRE:      rd_val = 16'(cfg_q[c].pre);
              default:               rd_val = '0;
            endcase
          end
        end
      end
    endcase
  end

  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      cfg_q     <= '0;
      o_arm     <= '0;
      o_sw_trig <= '0;
      o_rd_data <= '0;
    end else begin
      // pulses drop after one cycle
      o_arm     <= '0;
      o_sw_trig <= '0;
      o_rd_data <= i_reg.rd_en ? rd_val : 16'd0;
      if (i_reg.wr_en) begin
        if (i_reg.addr == wdc_pkg::ADR_ARM) begin
          o_arm <= i_reg.wdata[wdc_pkg::N_CHANNELS-1:0];
        end
        if (i_reg.addr == wdc_pkg::ADR_SW_TRIG) begin
          o_sw_trig <= i_reg.wdata[wdc_pkg::N_CHANNELS-1:0];
        end
        for (int c = 0; c < wdc_pkg::N_CHANNELS; c++) begin
          if (page_hit[c]) begin
            case (i_reg.addr[7:0])
              wdc_pkg::ADR_TRIG_SET: begin
                cfg_q[c].et        <= i_reg.wdata[0];
                cfg_q[c].gt        <= i_reg.wdata[1];
                cfg_q[c].lt        <= i_reg.wdata[2];
                cfg_q[c].thresh_en <= i_reg.wdata[3];
              end
              wdc_pkg::ADR_THRESH: cfg_q[c].threshold <= i_reg.wdata[11:0];
              // lengths clamp so the waveform fits the memory
              wdc_pkg::ADR_POST: cfg_q[c].post <= (i_reg.wdata > 16'(wdc_pkg::POST_MAX)) ?
                                                  6'(wdc_pkg::POST_MAX) : i_reg.wdata[5:0];
              wdc_pkg::ADR_PRE:  cfg_q[c].pre <= (i_reg.wdata > 16'(wdc_pkg::PRE_MAX)) ?
                                                 4'(wdc_pkg::PRE_MAX) : i_reg.wdata[3:0];
              default: ;
            endcase
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/wdc_top.sv
// ----------------------------------------------------------------------
// two-channel acquisition core, one 12-bit sample per channel per lclk
// ltc is zero in the first cycle after reset and counts every cycle
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module wdc_top (
  input  logic                                                     i_lclk,
  input  logic                                                     i_lclk_rst,
  input  wdc_pkg::reg_req_t                                        i_reg,
  input  logic [wdc_pkg::N_CHANNELS-1:0][wdc_pkg::SAMPLE_WIDTH-1:0] i_adc,
  input  logic                                                     i_ready,
  output logic [15:0]                                              o_rd_data,
  output wdc_pkg::rdout_word_u                                     o_word,
  output logic                                                     o_valid
);

  logic [wdc_pkg::LTC_WIDTH-1:0] ltc;

  wdc_pkg::trig_cfg_t [wdc_pkg::N_CHANNELS-1:0] cfg;
  wdc_pkg::hdr_word_t [wdc_pkg::N_CHANNELS-1:0] hdr;
  logic [wdc_pkg::N_CHANNELS-1:0][wdc_pkg::SAMPLE_WIDTH-1:0] rd_sample;
  logic [wdc_pkg::N_CHANNELS-1:0] arm;
  logic [wdc_pkg::N_CHANNELS-1:0] sw_trig;
  logic [wdc_pkg::N_CHANNELS-1:0] armed;
  logic [wdc_pkg::N_CHANNELS-1:0] trig;
  logic [wdc_pkg::N_CHANNELS-1:0] trig_sw;
  logic [wdc_pkg::N_CHANNELS-1:0] hdr_valid;
  logic [wdc_pkg::N_CHANNELS-1:0] rd_done;
  logic [wdc_pkg::WVB_ADR_WIDTH-1:0] rd_addr;

  // local time counter
  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      ltc <= '0;
    end else begin
      ltc <= ltc + 1'b1;
    end
  end

  wdc_regs u_regs (
    .i_lclk     (i_lclk),
    .i_lclk_rst (i_lclk_rst),
    .i_reg      (i_reg),
    .i_armed    (armed),
    .o_rd_data  (o_rd_data),
    .o_cfg      (cfg),
    .o_arm      (arm),
    .o_sw_trig  (sw_trig)
  );

  // per channel trigger and buffer
  for (genvar g = 0; g < wdc_pkg::N_CHANNELS; g++) begin : g_chan
    wvb_trigger u_trig (
      .i_lclk     (i_lclk),
      .i_lclk_rst (i_lclk_rst),
      .i_cfg      (cfg[g]),
      .i_sample   (i_adc[g]),
      .i_arm      (arm[g]),
      .i_armed    (armed[g]),
      .i_sw_trig  (sw_trig[g]),
      .o_trig     (trig[g]),
      .o_sw       (trig_sw[g])
    );

    wvb_buffer u_buf (
      .i_lclk      (i_lclk),
      .i_lclk_rst  (i_lclk_rst),
      .i_chan      (wdc_pkg::CHAN_WIDTH'(g)),
      .i_sample    (i_adc[g]),
      .i_ltc       (ltc),
      .i_cfg       (cfg[g]),
      .i_arm       (arm[g]),
      .i_trig      (trig[g]),
      .i_sw        (trig_sw[g]),
      .i_rd_addr   (rd_addr),
      .i_rd_done   (rd_done[g]),
      .o_armed     (armed[g]),
      .o_hdr_valid (hdr_valid[g]),
      .o_hdr       (hdr[g]),
      .o_rd_sample (rd_sample[g])
    );
  end

  wvb_reader u_reader (
    .i_lclk      (i_lclk),
    .i_lclk_rst  (i_lclk_rst),
    .i_hdr_valid (hdr_valid),
    .i_hdr       (hdr),
    .i_rd_sample (rd_sample),
    .i_ready     (i_ready),
    .o_rd_addr   (rd_addr),
    .o_rd_done   (rd_done),
    .o_word      (o_word),
    .o_valid     (o_valid)
  );

endmodule

`default_nettype wire

//--- design/wvb_buffer.sv
// ----------------------------------------------------------------------
// circular sample memory for one channel, holds one waveform at a time
// writes stop while a finished waveform waits, resume after rd_done
// rd_addr is the index inside the waveform, data one cycle later
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module wvb_buffer (
  input  logic                                i_lclk,
  input  logic                                i_lclk_rst,
  input  logic [wdc_pkg::CHAN_WIDTH-1:0]      i_chan,
  input  logic [wdc_pkg::SAMPLE_WIDTH-1:0]    i_sample,
  input  logic [wdc_pkg::LTC_WIDTH-1:0]       i_ltc,
  input  wdc_pkg::trig_cfg_t                  i_cfg,
  input  logic                                i_arm,
  input  logic                                i_trig,
  input  logic                                i_sw,
  input  logic [wdc_pkg::WVB_ADR_WIDTH-1:0]   i_rd_addr,
  input  logic                                i_rd_done,
  output logic                                o_armed,
  output logic                                o_hdr_valid,
  output wdc_pkg::hdr_word_t                  o_hdr,
  output logic [wdc_pkg::SAMPLE_WIDTH-1:0]    o_rd_sample
);

  logic [wdc_pkg::SAMPLE_WIDTH-1:0]  mem [wdc_pkg::WVB_DEPTH];
  logic [wdc_pkg::WVB_ADR_WIDTH-1:0] wr_ptr;
  logic [wdc_pkg::WVB_ADR_WIDTH-1:0] rd_base;
  logic [wdc_pkg::WVB_ADR_WIDTH-1:0] rd_ptr;
  logic [5:0] post_left;
  logic       armed;
  logic       in_post;
  logic       hold;
  logic       wr_en;

  // freeze history once the waveform is complete
  assign wr_en = !hold;

  // start of waveform plus index, wraps in the ring
  assign rd_ptr = rd_base + i_rd_addr;

  assign o_armed     = armed;
  assign o_hdr_valid = hold;

  // sample memory, registered read port
  always_ff @(posedge i_lclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_sample;
    end
    o_rd_sample <= mem[rd_ptr];
  end

  // capture sequencing
  // idle -> (trig) post -> hold -> (rd_done) idle
  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      wr_ptr    <= '0;
      post_left <= '0;
      armed     <= 1'b0;
      in_post   <= 1'b0;
      hold      <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_trig) begin
        // trigger beats a same-cycle arm
        armed     <= 1'b0;
        post_left <= i_cfg.post;
        in_post   <= (i_cfg.post != 6'd0);
        hold      <= (i_cfg.post == 6'd0);
      end else if (in_post) begin
        post_left <= post_left - 6'd1;
        // last post sample written on this edge
        if (post_left == 6'd1) begin
          in_post <= 1'b0;
          hold    <= 1'b1;
        end
      end else if (hold) begin
        if (i_rd_done) begin
          hold <= 1'b0;
        end
      end else if (i_arm) begin
        // arm only takes while idle
        armed <= 1'b1;
      end
    end
  end

  // header latch at the trigger sample
  always_ff @(posedge i_lclk) begin
    if (i_trig) begin
      rd_base    <= wr_ptr - 6'(i_cfg.pre);
      o_hdr.tag  <= wdc_pkg::TAG_HDR;
      o_hdr.chan <= i_chan;
      o_hdr.len  <= 6'(i_cfg.pre) + i_cfg.post + 6'd1;
      o_hdr.sw   <= i_sw;
      o_hdr.ltc  <= i_ltc[21:0];
    end
  end

endmodule

`default_nettype wire

//--- design/wvb_reader.sv
// ----------------------------------------------------------------------
// streams one header then len samples per waveform under valid/ready
// lowest pending channel first, one waveform in flight at a time
// o_rd_addr depends on i_ready in the same cycle
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module wvb_reader (
  input  logic                                               i_lclk,
  input  logic                                               i_lclk_rst,
  input  logic [wdc_pkg::N_CHANNELS-1:0]                     i_hdr_valid,
  input  wdc_pkg::hdr_word_t [wdc_pkg::N_CHANNELS-1:0]       i_hdr,
  input  logic [wdc_pkg::N_CHANNELS-1:0][wdc_pkg::SAMPLE_WIDTH-1:0] i_rd_sample,
  input  logic                                               i_ready,
  output logic [wdc_pkg::WVB_ADR_WIDTH-1:0]                  o_rd_addr,
  output logic [wdc_pkg::N_CHANNELS-1:0]                     o_rd_done,
  output wdc_pkg::rdout_word_u                               o_word,
  output logic                                               o_valid
);

  logic [wdc_pkg::CHAN_WIDTH-1:0]    pick;
  logic [wdc_pkg::CHAN_WIDTH-1:0]    sel;
  logic [wdc_pkg::WVB_ADR_WIDTH-1:0] nxt;
  logic [wdc_pkg::WVB_ADR_WIDTH-1:0] len;
  logic any_pend;
  logic fire;
  logic done_word;
  logic load_hdr;
  logic load_smp;

  // lowest index wins
  always_comb begin
    any_pend = 1'b0;
    pick     = '0;
    for (int c = wdc_pkg::N_CHANNELS - 1; c >= 0; c--) begin
      if (i_hdr_valid[c]) begin
        any_pend = 1'b1;
        pick     = wdc_pkg::CHAN_WIDTH'(c);
      end
    end
  end

  assign fire      = o_valid && i_ready;
  // final sample accepted
  assign done_word = fire && (o_word.smp.tag == wdc_pkg::TAG_SMP) && o_word.smp.last;
  assign load_hdr  = !o_valid && any_pend;
  assign load_smp  = fire && !done_word;

  // address runs one ahead of the word on the output
  assign o_rd_addr = fire ? (nxt + 6'd1) : nxt;

  always_comb begin
    o_rd_done      = '0;
    o_rd_done[sel] = done_word;
  end

  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      o_valid <= 1'b0;
      sel     <= '0;
      nxt     <= '0;
    end else if (load_hdr) begin
      o_valid <= 1'b1;
      sel     <= pick;
      nxt     <= '0;
    end else if (done_word) begin
      o_valid <= 1'b0;
      nxt     <= '0;
    end else if (fire) begin
      nxt <= nxt + 6'd1;
    end
  end

  // output word, header or sample view
  always_ff @(posedge i_lclk) begin
    if (load_hdr) begin
      o_word.hdr <= i_hdr[pick];
      len        <= i_hdr[pick].len;
    end else if (load_smp) begin
      o_word.smp.tag    <= wdc_pkg::TAG_SMP;
      o_word.smp.last   <= (nxt == (len - 6'd1));
      o_word.smp.index  <= nxt;
      o_word.smp.pad    <= '0;
      o_word.smp.sample <= i_rd_sample[sel];
    end
  end

endmodule

`default_nettype wire

//--- design/wvb_trigger.sv
// ----------------------------------------------------------------------
// per-channel trigger, decided combinationally on the incoming sample
// triggers pass only while armed and after pre samples since the arm
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module wvb_trigger (
  input  logic                              i_lclk,
  input  logic                              i_lclk_rst,
  input  wdc_pkg::trig_cfg_t                i_cfg,
  input  logic [wdc_pkg::SAMPLE_WIDTH-1:0]  i_sample,
  input  logic                              i_arm,
  input  logic                              i_armed,
  input  logic                              i_sw_trig,
  output logic                              o_trig,
  output logic                              o_sw
);

  logic       cond;
  logic       cond_q;
  logic       thr_fire;
  logic       gate;
  logic [3:0] fill_cnt;

  // threshold condition, any enabled compare
  always_comb begin
    cond = i_cfg.thresh_en &&
           ((i_cfg.gt && (i_sample > i_cfg.threshold)) ||
            (i_cfg.lt && (i_sample < i_cfg.threshold)) ||
            (i_cfg.et && (i_sample == i_cfg.threshold)));
  end

  // rising edge of the condition only
  assign thr_fire = cond && !cond_q;

  // enough history behind the trigger sample
  assign gate = i_armed && (fill_cnt >= i_cfg.pre);

  assign o_trig = gate && (i_sw_trig || thr_fire);
  // sw wins a tie with threshold
  assign o_sw   = gate && i_sw_trig;

  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      cond_q   <= 1'b0;
      fill_cnt <= '0;
    end else begin
      cond_q <= cond;
      // counts samples after the arm pulse, saturates
      if (i_arm) begin
        fill_cnt <= '0;
      end else if (fill_cnt != 4'(wdc_pkg::PRE_MAX)) begin
        fill_cnt <= fill_cnt + 4'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/wdc_checker.sv
// ----------------------------------------------------------------------
// readout handshake properties, bound into wvb_reader
// only the output side of the stream is observed
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module wdc_checker (
  input logic                 i_lclk,
  input logic                 i_lclk_rst,
  input logic                 i_ready,
  input logic                 i_valid,
  input wdc_pkg::rdout_word_u i_word
);

  // valid low once reset has been seen
  a_valid_in_reset: assert property (@(posedge i_lclk) i_lclk_rst |=> !i_valid)
    else $error("o_valid high after a reset cycle");

  // stalled word holds still
  a_hold_stall: assert property (@(posedge i_lclk) disable iff (i_lclk_rst)
    (i_valid && !i_ready) |=> (i_valid && $stable(i_word)))
    else $error("o_word or o_valid changed while stalled");

  // stream drops after the last sample
  a_drop_after_last: assert property (@(posedge i_lclk) disable iff (i_lclk_rst)
    (i_valid && i_ready && (i_word.smp.tag == wdc_pkg::TAG_SMP) && i_word.smp.last)
    |=> !i_valid)
    else $error("o_valid stayed high after a last sample");

  // every new waveform opens with a header
  a_hdr_first: assert property (@(posedge i_lclk) disable iff (i_lclk_rst)
    $rose(i_valid) |-> (i_word.hdr.tag == wdc_pkg::TAG_HDR))
    else $error("first word of a waveform is not a header");

endmodule

bind wvb_reader wdc_checker u_checker (
  .i_lclk     (i_lclk),
  .i_lclk_rst (i_lclk_rst),
  .i_ready    (i_ready),
  .i_valid    (o_valid),
  .i_word     (o_word)
);

`default_nettype wire

//--- test/wdc_tb.sv
// ----------------------------------------------------------------------
// random stimulus from a fixed seed, checked against a cycle model
// model follows arm, pre-fill gate, capture and readout per channel
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module wdc_tb;

  logic                      lclk;
  logic                      lclk_rst;
  wdc_pkg::reg_req_t         reg_req;
  logic [1:0][11:0]          adc;
  logic                      ready;
  logic [15:0]               rd_data;
  wdc_pkg::rdout_word_u      word;
  logic                      valid;

  // model state, one entry per channel
  wdc_pkg::trig_cfg_t m_cfg [2];
  wdc_pkg::hdr_word_t m_hdr [2];
  wdc_pkg::hdr_word_t exp_hdr [2];
  logic [1:0]  m_arm_p;
  logic [1:0]  m_sw_p;
  logic        m_armed [2];
  logic        m_cond_q [2];
  logic        m_in_post [2];
  logic        m_hold [2];
  logic        exp_valid [2];
  int          m_fill [2];
  int          m_post_left [2];
  int          m_trig_idx [2];
  int          m_pre [2];
  logic [11:0] hist [2][$];
  logic [11:0] exp_smp [2][64];
  logic [47:0] m_ltc;
  logic [11:0] thr_set [2];
  logic        rd_pend;
  logic [15:0] rd_exp;
  logic        rx_active;
  int          rx_chan;
  int          rx_idx;
  int          errors;
  int          n_wave;
  int          n_sw;
  int          n_thr;
  int          n_gated;

  wdc_top u_wdc_top (
    .i_lclk     (lclk),
    .i_lclk_rst (lclk_rst),
    .i_reg      (reg_req),
    .i_adc      (adc),
    .i_ready    (ready),
    .o_rd_data  (rd_data),
    .o_word     (word),
    .o_valid    (valid)
  );

  initial begin
    lclk = 1'b0;
    forever #50 lclk = ~lclk;
  end

  // hang guard
  initial begin
    #30_000_000;
    $display("simulation ran past its time limit");
    $display("ERRORS FOUND");
    $finish;
  end

  task automatic expect_eq(string name, logic [31:0] got, logic [31:0] exp);
    if (got != exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  function automatic logic cond_of(wdc_pkg::trig_cfg_t cfg, logic [11:0] s);
    return cfg.thresh_en && ((cfg.gt && (s > cfg.threshold)) ||
                             (cfg.lt && (s < cfg.threshold)) ||
                             (cfg.et && (s == cfg.threshold)));
  endfunction

  // register value the model predicts for a read
  function automatic logic [15:0] read_value(logic [11:0] addr);
    logic [15:0] v;
    v = '0;
    if (addr == 12'hfff) begin
      v = 16'h000a;
    end else if (addr == 12'hff9) begin
      v = {14'd0, m_armed[1], m_armed[0]};
    end else begin
      for (int c = 0; c < 2; c++) begin
        if (addr[11:8] == 4'hf - 4'(c)) begin
          case (addr[7:0])
            8'hfe: v = {12'd0, m_cfg[c].thresh_en, m_cfg[c].lt, m_cfg[c].gt, m_cfg[c].et};
            8'hfd: v = {4'd0, m_cfg[c].threshold};
            8'hf5: v = {10'd0, m_cfg[c].post};
            8'hf4: v = {12'd0, m_cfg[c].pre};
            default: v = '0;
          endcase
        end
      end
    end
    return v;
  endfunction

  // copy the finished waveform out of the history
  task automatic finish_wave(int c);
    int first;
    int len;
    first = m_trig_idx[c] - m_pre[c];
    len = int'(m_hdr[c].len);
    if (exp_valid[c]) begin
      errors++;
      $display("channel %0d completed a waveform while one was still unread", c);
    end
    if (first < 0) begin
      errors++;
      $display("channel %0d triggered without enough history", c);
      first = 0;
    end
    for (int i = 0; i < len; i++) begin
      exp_smp[c][i] = hist[c][first + i];
    end
    exp_hdr[c]   = m_hdr[c];
    exp_valid[c] = 1'b1;
    m_hold[c]    = 1'b1;
  endtask

  // one accepted readout word against the expected stream
  task automatic check_word(inout logic [1:0] done);
    wdc_pkg::smp_word_t e;
    int ch;
    int len;
    if (!rx_active) begin
      ch = int'(word.hdr.chan);
      if (word.hdr.tag != wdc_pkg::TAG_HDR) begin
        expect_eq("o_word.hdr.tag", 32'(word.hdr.tag), 32'(wdc_pkg::TAG_HDR));
      end else if (!exp_valid[ch]) begin
        errors++;
        $display("header for channel %0d arrived with no waveform captured", ch);
      end else begin
        expect_eq("o_word.hdr", word, exp_hdr[ch]);
        rx_active = 1'b1;
        rx_chan   = ch;
        rx_idx    = 0;
      end
    end else begin
      len      = int'(exp_hdr[rx_chan].len);
      e.tag    = wdc_pkg::TAG_SMP;
      e.last   = (rx_idx == len - 1);
      e.index  = 6'(rx_idx);
      e.pad    = '0;
      e.sample = exp_smp[rx_chan][rx_idx];
      expect_eq("o_word.smp", word, e);
      if (rx_idx == len - 1) begin
        done[rx_chan]      = 1'b1;
        exp_valid[rx_chan] = 1'b0;
        rx_active          = 1'b0;
        n_wave++;
        if (exp_hdr[rx_chan].sw) n_sw++;
        else n_thr++;
      end else begin
        rx_idx++;
      end
    end
  endtask

  // reference model and scoreboard, steps on every edge
  always @(posedge lclk) begin : model
    logic [1:0] done;
    logic       cond;
    logic       cand;
    logic       gate;
    logic       trig;
    done = '0;
    if (lclk_rst) begin
      for (int c = 0; c < 2; c++) begin
        m_cfg[c]     = '0;
        m_armed[c]   = 1'b0;
        m_cond_q[c]  = 1'b0;
        m_in_post[c] = 1'b0;
        m_hold[c]    = 1'b0;
        m_fill[c]    = 0;
        exp_valid[c] = 1'b0;
        hist[c].delete();
      end
      m_arm_p   = '0;
      m_sw_p    = '0;
      rd_pend   = 1'b0;
      rx_active = 1'b0;
      m_ltc     = '0;
    end else begin
      if (valid && ready) check_word(done);
      if (rd_pend) expect_eq("o_rd_data", 32'(rd_data), 32'(rd_exp));
      rd_pend = reg_req.rd_en;
      if (reg_req.rd_en) rd_exp = read_value(reg_req.addr);
      for (int c = 0; c < 2; c++) begin
        cond = cond_of(m_cfg[c], adc[c]);
        cand = m_sw_p[c] || (cond && !m_cond_q[c]);
        gate = m_armed[c] && (m_fill[c] >= int'(m_cfg[c].pre));
        trig = gate && cand;
        if (m_armed[c] && !gate && cand) n_gated++;
        if (!m_hold[c]) hist[c].push_back(adc[c]);
        if (trig) begin
          m_armed[c]    = 1'b0;
          m_trig_idx[c] = hist[c].size() - 1;
          m_pre[c]      = int'(m_cfg[c].pre);
          m_hdr[c].tag  = wdc_pkg::TAG_HDR;
          m_hdr[c].chan = 1'(c);
          m_hdr[c].len  = 6'(m_pre[c] + int'(m_cfg[c].post) + 1);
          m_hdr[c].sw   = m_sw_p[c];
          m_hdr[c].ltc  = m_ltc[21:0];
          m_post_left[c] = int'(m_cfg[c].post);
          m_in_post[c]   = (m_post_left[c] != 0);
          if (m_post_left[c] == 0) finish_wave(c);
        end else if (m_in_post[c]) begin
          m_post_left[c]--;
          if (m_post_left[c] == 0) begin
            m_in_post[c] = 1'b0;
            finish_wave(c);
          end
        end else if (m_hold[c]) begin
          if (done[c]) m_hold[c] = 1'b0;
        end else if (m_arm_p[c]) begin
          m_armed[c] = 1'b1;
        end
        if (m_arm_p[c]) m_fill[c] = 0;
        else if (m_fill[c] != 15) m_fill[c]++;
        m_cond_q[c] = cond;
      end
      // register writes land after this edge
      m_arm_p = '0;
      m_sw_p  = '0;
      if (reg_req.wr_en) begin
        if (reg_req.addr == 12'hffa) m_arm_p = reg_req.wdata[1:0];
        if (reg_req.addr == 12'hffc) m_sw_p = reg_req.wdata[1:0];
        for (int c = 0; c < 2; c++) begin
          if (reg_req.addr[11:8] == 4'hf - 4'(c)) begin
            case (reg_req.addr[7:0])
              8'hfe: {m_cfg[c].thresh_en, m_cfg[c].lt, m_cfg[c].gt, m_cfg[c].et} =
                       reg_req.wdata[3:0];
              8'hfd: m_cfg[c].threshold = reg_req.wdata[11:0];
              8'hf5: m_cfg[c].post = reg_req.wdata[5:0];
              8'hf4: m_cfg[c].pre = reg_req.wdata[3:0];
              default: ;
            endcase
          end
        end
      end
      m_ltc = m_ltc + 48'd1;
    end
  end

  // samples near the threshold, ready low about 30% of cycles
  task automatic drive_stream();
    forever begin
      @(posedge lclk);
      ready <= ($urandom_range(0, 9) >= 3);
      for (int c = 0; c < 2; c++) begin
        if ($urandom_range(0, 7) == 0) adc[c] <= 12'($urandom);
        else adc[c] <= thr_set[c] + 12'($urandom_range(0, 16)) - 12'd8;
      end
    end
  endtask

  task automatic reg_write(logic [11:0] addr, logic [15:0] data);
    reg_req <= '{wr_en: 1'b1, rd_en: 1'b0, addr: addr, wdata: data};
    @(posedge lclk);
    reg_req <= '0;
  endtask

  // data comes back one cycle after rd_en is sampled
  task automatic reg_read(logic [11:0] addr, output logic [15:0] data);
    reg_req <= '{wr_en: 1'b0, rd_en: 1'b1, addr: addr, wdata: 16'd0};
    @(posedge lclk);
    reg_req <= '0;
    @(posedge lclk);
    data = rd_data;
  endtask

  task automatic set_channel(int ch, logic [3:0] tset, logic [11:0] thr,
                             logic [3:0] pre, logic [5:0] post);
    logic [3:0]  page;
    logic [15:0] d;
    page = 4'hf - 4'(ch);
    thr_set[ch] = thr;
    reg_write({page, 8'hfe}, {12'd0, tset});
    reg_write({page, 8'hfd}, {4'd0, thr});
    reg_write({page, 8'hf4}, {12'd0, pre});
    reg_write({page, 8'hf5}, {10'd0, post});
    reg_read({page, 8'hfe}, d);
    expect_eq("trig_set readback", 32'(d), 32'(tset));
    reg_read({page, 8'hfd}, d);
    expect_eq("threshold readback", 32'(d), 32'(thr));
    reg_read({page, 8'hf4}, d);
    expect_eq("pre readback", 32'(d), 32'(pre));
    reg_read({page, 8'hf5}, d);
    expect_eq("post readback", 32'(d), 32'(post));
  endtask

  task automatic wait_drained();
    int t;
    t = 0;
    // a write sampled on this edge triggers on the next one
    repeat (2) @(posedge lclk);
    while ((exp_valid[0] || exp_valid[1] || m_in_post[0] || m_in_post[1] || rx_active)
           && t < 5000) begin
      @(posedge lclk);
      t++;
    end
    if (t >= 5000) begin
      errors++;
      $display("readout did not drain within 5000 cycles");
    end
  endtask

  initial begin : stim
    logic [15:0] d;
    int          base;
    int          n_busy;
    void'($urandom(18006));
    lclk_rst = 1'b1;
    reg_req  = '0;
    adc      = '0;
    ready    = 1'b0;
    thr_set[0] = 12'h800;
    thr_set[1] = 12'h400;
    errors = 0;
    n_wave = 0;
    n_sw = 0;
    n_thr = 0;
    n_gated = 0;
    fork
      drive_stream();
    join_none
    repeat (2) @(posedge lclk);
    lclk_rst <= 1'b0;
    @(posedge lclk);

    reg_read(12'hfff, d);
    expect_eq("version", 32'(d), 32'h000a);
    set_channel(0, 4'b1010, 12'h800, 4'd4, 6'd10);
    set_channel(1, 4'b1100, 12'h400, 4'd15, 6'd47);

    // random arm, sw trigger, reconfigure and armed reads
    for (int n = 0; n < 400; n++) begin
      case ($urandom_range(0, 9))
        0, 1, 2, 3: reg_write(12'hffa, 16'($urandom_range(1, 3)));
        4, 5: reg_write(12'hffc, 16'($urandom_range(1, 3)));
        6: set_channel($urandom_range(0, 1), {1'b1, 3'($urandom_range(1, 7))},
                       12'($urandom), 4'($urandom_range(0, 15)),
                       6'($urandom_range(0, 47)));
        7: reg_read(12'hff9, d);
        default: ;
      endcase
      repeat ($urandom_range(0, 30)) @(posedge lclk);
    end
    // thresholds off so no new capture starts
    reg_write(12'hffe, 16'd0);
    reg_write(12'hefe, 16'd0);
    wait_drained();

    // both channels armed, early sw trigger gated, then both at once
    set_channel(0, 4'b0000, 12'h100, 4'd15, 6'd5);
    set_channel(1, 4'b0000, 12'h200, 4'd15, 6'd20);
    base = n_gated;
    reg_write(12'hffa, 16'd3);
    reg_write(12'hffc, 16'd3);
    // gate decision falls on the edge after the pulse
    repeat (2) @(posedge lclk);
    if (n_gated != base + 2) begin
      errors++;
      $display("sw trigger before pre-fill was not ignored on both channels");
    end
    reg_read(12'hff9, d);
    expect_eq("armed after arm", 32'(d), 32'd3);
    repeat (20) @(posedge lclk);
    base = n_wave;
    reg_write(12'hffc, 16'd3);
    wait_drained();
    expect_eq("waveforms from dual capture", 32'(n_wave - base), 32'd2);
    reg_read(12'hff9, d);
    expect_eq("armed after trigger", 32'(d), 32'd0);
    reg_write(12'hffc, 16'd3);
    // disarmed channels stay silent
    n_busy = 0;
    for (int i = 0; i < 200; i++) begin
      @(posedge lclk);
      if (valid) n_busy++;
    end
    if (n_busy != 0) begin
      errors++;
      $display("readout became active without a re-arm");
    end

    if (n_sw == 0 || n_thr == 0 || n_gated == 0) begin
      errors++;
      $display("run missed a case: sw %0d threshold %0d gated %0d", n_sw, n_thr, n_gated);
    end
    $display("summary: %0d errors, %0d waveforms (%0d sw, %0d threshold), %0d gated",
             errors, n_wave, n_sw, n_thr, n_gated);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
